// File: frontend_pkg.sv
// widths, halfword types and the request state enum shared by the
// instruction fetch front end
`default_nettype none

package frontend_pkg;

	// ---------------------------------------------------------
	// bus and instruction widths
	// ---------------------------------------------------------

	// byte address width of the fetch bus
	localparam int w_addr = 32;
	// the bus always returns one full word per request
	localparam int w_data = 32;
	// one instruction parcel, the size of a compressed instruction
	localparam int w_hw = 16;

	typedef logic [w_addr-1:0] addr_t;
	typedef logic [w_data-1:0] word_t;

	// ---------------------------------------------------------
	// halfword bookkeeping
	// ---------------------------------------------------------

	// bit 0 flags the lower halfword of a word, bit 1 the upper halfword
	typedef logic [1:0] hw_mask_t;

	// a count of halfwords from 0 to 3, used for the buffer level and
	// for the decode window valid and use counts
	typedef logic [1:0] hw_count_t;

	// request state of the fetch sequencer
	typedef enum logic [1:0] {
		// held through reset and for the edge that leaves it
		SEQ_RESET,
		// requests and jumps go out freely
		SEQ_RUN,
		// an address was offered but not taken, it must stay put
		SEQ_HOLD
	} seq_state_e;

endpackage

`default_nettype wire

// File: fetch_sequencer.sv
// fetch address counter, bus request generation, in-flight count and
// discard tracking for responses that belong to an abandoned path
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
	parameter frontend_pkg::addr_t reset_vector = '0
) (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire frontend_pkg::addr_t    jump_target,
	input  wire                         jump_target_vld,
	output logic                        jump_target_rdy,
	output frontend_pkg::addr_t         mem_addr,
	output logic                        mem_addr_vld,
	input  wire                         mem_addr_rdy,
	input  wire                         mem_data_vld,
	input  wire                         q_full,
	input  wire                         q_almost_full,
	output logic                        jump_now,
	output logic                        flush_pending,
	output frontend_pkg::hw_mask_t      mem_data_hwvld
);

	frontend_pkg::seq_state_e state;
	// runs ahead of decode in word steps
	frontend_pkg::addr_t fetch_addr;
	frontend_pkg::addr_t jump_addr;
	logic [1:0] pending;
	logic [1:0] flush_ctr;
	// the first kept word after a jump starts on its upper halfword
	logic first_odd;
	logic fetch_stall;
	logic addr_acc;

	// ---------------------------------------------------------
	// request generation
	// ---------------------------------------------------------

	// jumps are refused only while an address is held on the bus
	assign jump_target_rdy = state == frontend_pkg::SEQ_RUN;
	assign jump_now = jump_target_vld && jump_target_rdy;

	// the bus only sees word addresses, halfword offset goes to first_odd
	assign jump_addr = {jump_target[frontend_pkg::w_addr-1:2], 2'b00};

	// registered counts only, so there is no path from the data phase
	// back into the address phase
	assign fetch_stall = q_full || (q_almost_full && |pending) || pending[1];

	assign addr_acc = mem_addr_vld && mem_addr_rdy;

	always_comb begin
		mem_addr = fetch_addr;
		mem_addr_vld = 1'b0;
		case (state)
		frontend_pkg::SEQ_HOLD: begin
			// fetch_addr already holds whatever was offered last cycle
			mem_addr_vld = 1'b1;
		end
		frontend_pkg::SEQ_RUN: begin
			if (jump_target_vld) begin
				mem_addr = jump_addr;
				// flushed responses still count, two in flight is the limit
				mem_addr_vld = !pending[1];
			end else begin
				mem_addr_vld = !fetch_stall;
			end
		end
		default: begin
			mem_addr_vld = 1'b0;
		end
		endcase
	end

	// ---------------------------------------------------------
	// state and fetch address
	// ---------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= frontend_pkg::SEQ_RESET;
			fetch_addr <= reset_vector;
		end else begin
			if (state == frontend_pkg::SEQ_RESET) begin
				state <= frontend_pkg::SEQ_RUN;
			end else if (mem_addr_vld && !mem_addr_rdy) begin
				state <= frontend_pkg::SEQ_HOLD;
			end else begin
				state <= frontend_pkg::SEQ_RUN;
			end
			// a jump that goes straight through is post-incremented,
			// otherwise the target waits here to be issued or held
			if (jump_now) begin
				fetch_addr <= jump_addr + (addr_acc ? 32'd4 : 32'd0);
			end else if (addr_acc) begin
				fetch_addr <= fetch_addr + 32'd4;
			end
		end
	end

	// ---------------------------------------------------------
	// in-flight and discard tracking
	// ---------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 2'd0;
			flush_ctr <= 2'd0;
			first_odd <= 1'b0;
		end else begin
			pending <= pending + {1'b0, addr_acc} - {1'b0, mem_data_vld};
			// everything still due at a jump is on the old path, a
			// response in the jump cycle itself is dropped by the jump
			if (jump_now) begin
				flush_ctr <= pending - {1'b0, mem_data_vld};
			end else if (|flush_ctr && mem_data_vld) begin
				flush_ctr <= flush_ctr - 2'd1;
			end
			// responses come back in order, so the first one not
			// discarded is the word holding the jump target
			if (jump_now) begin
				first_odd <= jump_target[1];
			end else if (mem_data_vld && !flush_pending) begin
				first_odd <= 1'b0;
			end
		end
	end

	assign flush_pending = |flush_ctr;
	assign mem_data_hwvld = {1'b1, !first_odd};

	a_pending_max: assert property (@(posedge clk) disable iff (!rst_n)
		pending != 2'd3)
		else $error("fetch_sequencer: more than two fetches in flight");

	a_flush_le_pending: assert property (@(posedge clk) disable iff (!rst_n)
		flush_ctr <= pending)
		else $error("fetch_sequencer: discard count above in-flight count");

	// the bus must not answer a request that was never made
	a_no_orphan_data: assert property (@(posedge clk) disable iff (!rst_n)
		mem_data_vld |-> pending != 2'd0)
		else $error("fetch_sequencer: data response with nothing pending");

endmodule

`default_nettype wire

// File: prefetch_queue.sv
// two-entry shift queue of fetched words with halfword valids and bus
// error bits, sitting beside the bypass path into the instruction buffer
`timescale 1ns/1ps
`default_nettype none

module prefetch_queue (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire frontend_pkg::word_t    mem_data,
	input  wire                         mem_data_err,
	input  wire                         mem_data_vld,
	input  wire frontend_pkg::hw_mask_t mem_data_hwvld,
	input  wire                         flush_pending,
	input  wire                         jump_now,
	input  wire                         room_for_fetch,
	output frontend_pkg::word_t         head_data,
	output frontend_pkg::hw_mask_t      head_hwvld,
	output logic                        head_err,
	output logic                        q_empty,
	output logic                        q_full,
	output logic                        q_almost_full
);

	// two entries keep the bus busy while decode stalls
	localparam int q_depth = 2;

	frontend_pkg::word_t    q_data  [q_depth];
	logic                   q_err   [q_depth];
	frontend_pkg::hw_mask_t q_hwvld [q_depth];
	logic [q_depth-1:0]     q_vld;

	// view of the entry above each one, the bus sits above the top entry
	frontend_pkg::word_t    up_data  [q_depth];
	logic                   up_err   [q_depth];
	frontend_pkg::hw_mask_t up_hwvld [q_depth];
	logic [q_depth-1:0]     up_vld;
	logic [q_depth-1:0]     below_vld;

	logic push;
	logic pop;

	always_comb begin
		for (int i = 0; i < q_depth; i++) begin
			q_vld[i] = |q_hwvld[i];
		end
		for (int i = 0; i < q_depth - 1; i++) begin
			up_data[i] = q_data[i+1];
			up_err[i] = q_err[i+1];
			up_hwvld[i] = q_hwvld[i+1];
		end
		up_data[q_depth-1] = mem_data;
		up_err[q_depth-1] = mem_data_err;
		up_hwvld[q_depth-1] = 2'b00;
	end

	assign up_vld = {1'b0, q_vld[q_depth-1:1]};
	// entry 0 can always take a push, higher ones only on top of data
	assign below_vld = {q_vld[q_depth-2:0], 1'b1};

	assign q_empty = !q_vld[0];
	assign q_almost_full = q_vld[q_depth-2];
	assign q_full = q_vld[q_depth-1];

	// a word the buffer takes straight from the bus must not be stored too
	assign push = mem_data_vld && !flush_pending && !(room_for_fetch && q_empty);
	assign pop = room_for_fetch && !q_empty;

	// ---------------------------------------------------------
	// entry update
	// ---------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < q_depth; i++) begin
				q_hwvld[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < q_depth; i++) begin
				if (jump_now) begin
					q_hwvld[i] <= 2'b00;
				end else if (up_vld[i] && pop) begin
					q_hwvld[i] <= up_hwvld[i];
				end else if (q_vld[i] && pop) begin
					// top valid entry drains, a same-cycle push lands here
					q_hwvld[i] <= push ? mem_data_hwvld : 2'b00;
				end else if (!q_vld[i] && push && !pop && below_vld[i]) begin
					q_hwvld[i] <= mem_data_hwvld;
				end
			end
		end
	end

	// payload follows the valids and needs no clearing
	always_ff @(posedge clk) begin
		for (int i = 0; i < q_depth; i++) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= up_vld[i] ? up_data[i] : mem_data;
				q_err[i] <= up_vld[i] ? up_err[i] : mem_data_err;
			end
		end
	end

	assign head_data = q_data[0];
	assign head_hwvld = q_hwvld[0];
	assign head_err = q_err[0];

	// the head is always entry 0, so valid entries must stay packed
	a_compact: assert property (@(posedge clk) disable iff (!rst_n)
		q_vld[1] |-> q_vld[0])
		else $error("prefetch_queue: entry 1 valid above an empty entry 0");

endmodule

`default_nettype wire

// File: instr_buffer.sv
// three-halfword shift buffer forming the current instruction register,
// with queue pop and bus bypass control
`timescale 1ns/1ps
`default_nettype none

module instr_buffer (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire frontend_pkg::word_t       mem_data,
	input  wire                            mem_data_err,
	input  wire                            mem_data_vld,
	input  wire frontend_pkg::hw_mask_t    mem_data_hwvld,
	input  wire                            flush_pending,
	input  wire                            jump_now,
	input  wire frontend_pkg::word_t       head_data,
	input  wire frontend_pkg::hw_mask_t    head_hwvld,
	input  wire                            head_err,
	input  wire                            q_empty,
	input  wire frontend_pkg::hw_count_t   cir_use,
	output logic                           room_for_fetch,
	output logic [2*frontend_pkg::w_hw-1:0] cir,
	output frontend_pkg::hw_count_t        cir_vld,
	output frontend_pkg::hw_mask_t         cir_err
);

	// slots 0 and 1 are the decode window, slot 2 absorbs misalignment
	// between the window and word-aligned fetch data
	localparam int n_slot = 3;

	logic [frontend_pkg::w_hw-1:0] slot_hw     [n_slot];
	logic                          slot_err    [n_slot];
	logic [frontend_pkg::w_hw-1:0] shifted_hw  [n_slot];
	logic                          shifted_err [n_slot];
	logic [frontend_pkg::w_hw-1:0] next_hw     [n_slot];
	logic                          next_err    [n_slot];
	frontend_pkg::hw_count_t level;
	frontend_pkg::hw_count_t level_no_fetch;
	frontend_pkg::hw_count_t fill;
	frontend_pkg::hw_count_t level_next;

	logic                          fetch_vld;
	frontend_pkg::word_t           fetch_data;
	frontend_pkg::hw_mask_t        fetch_hwvld;
	logic                          fetch_err;
	logic [frontend_pkg::w_hw-1:0] fetch_lo;
	logic [frontend_pkg::w_hw-1:0] fetch_hi;

	// ---------------------------------------------------------
	// fetch word select
	// ---------------------------------------------------------

	// the queue head is older than anything on the bus
	assign fetch_vld = !q_empty || (mem_data_vld && !flush_pending);
	assign fetch_data = q_empty ? mem_data : head_data;
	assign fetch_hwvld = q_empty ? mem_data_hwvld : head_hwvld;
	assign fetch_err = q_empty ? mem_data_err : head_err;

	// a word entered at its upper halfword is moved down to the bottom
	assign fetch_hi = fetch_data[frontend_pkg::w_hw +: frontend_pkg::w_hw];
	assign fetch_lo = fetch_hwvld[0] ? fetch_data[0 +: frontend_pkg::w_hw] : fetch_hi;

	// ---------------------------------------------------------
	// shift out consumed halfwords, then overlay fresh data
	// ---------------------------------------------------------

	always_comb begin
		shifted_hw = slot_hw;
		shifted_err = slot_err;
		if (cir_use == 2'd2) begin
			shifted_hw[0] = slot_hw[2];
			shifted_err[0] = slot_err[2];
		end else if (cir_use == 2'd1) begin
			shifted_hw[0] = slot_hw[1];
			shifted_err[0] = slot_err[1];
			shifted_hw[1] = slot_hw[2];
			shifted_err[1] = slot_err[2];
		end
	end

	assign level_no_fetch = level - cir_use;

	// a full word needs two free slots, a half word only one
	assign room_for_fetch = level_no_fetch <= ((&fetch_hwvld) ? 2'd1 : 2'd2);

	always_comb begin
		next_hw = shifted_hw;
		next_err = shifted_err;
		if (room_for_fetch) begin
			case (level_no_fetch)
			2'd0: begin
				next_hw[0] = fetch_lo;
				next_err[0] = fetch_err;
				next_hw[1] = fetch_hi;
				next_err[1] = fetch_err;
			end
			2'd1: begin
				next_hw[1] = fetch_lo;
				next_err[1] = fetch_err;
				next_hw[2] = fetch_hi;
				next_err[2] = fetch_err;
			end
			default: begin
				next_hw[2] = fetch_lo;
				next_err[2] = fetch_err;
			end
			endcase
		end
	end

	assign fill = (room_for_fetch && fetch_vld) ? ((&fetch_hwvld) ? 2'd2 : 2'd1) : 2'd0;
	assign level_next = jump_now ? 2'd0 : level_no_fetch + fill;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= 2'd0;
			cir_vld <= 2'd0;
		end else begin
			level <= level_next;
			// decode only ever sees up to two halfwords
			cir_vld <= (level_next == 2'd3) ? 2'd2 : level_next;
		end
	end

	always_ff @(posedge clk) begin
		slot_hw <= next_hw;
		slot_err <= next_err;
	end

	assign cir = {slot_hw[1], slot_hw[0]};
	assign cir_err = {slot_err[1], slot_err[0]};

	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use <= cir_vld)
		else $error("instr_buffer: decode used more halfwords than valid");

	// at most one word arrives per cycle, so 0 to 3 means an underflow
	a_level_step: assert property (@(posedge clk) disable iff (!rst_n)
		level == 2'd0 |=> level != 2'd3)
		else $error("instr_buffer: level went from 0 to 3 in one cycle");

endmodule

`default_nettype wire

// File: frontend_top.sv
// top level of the fetch front end, joining the sequencer, the prefetch
// queue and the instruction buffer to the bus, jump and decode ports
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
	parameter frontend_pkg::addr_t reset_vector = '0
) (
	input  wire                             clk,
	input  wire                             rst_n,
	// bus address phase
	output frontend_pkg::addr_t             mem_addr,
	output logic                            mem_addr_vld,
	input  wire                             mem_addr_rdy,
	// bus data phase, no back-pressure
	input  wire frontend_pkg::word_t        mem_data,
	input  wire                             mem_data_err,
	input  wire                             mem_data_vld,
	// redirect from the core
	input  wire frontend_pkg::addr_t        jump_target,
	input  wire                             jump_target_vld,
	output logic                            jump_target_rdy,
	// decode window
	output logic [2*frontend_pkg::w_hw-1:0] cir,
	output frontend_pkg::hw_count_t         cir_vld,
	input  wire frontend_pkg::hw_count_t    cir_use,
	output frontend_pkg::hw_mask_t          cir_err
);

	logic                   jump_now;
	logic                   flush_pending;
	frontend_pkg::hw_mask_t mem_data_hwvld;
	frontend_pkg::word_t    head_data;
	frontend_pkg::hw_mask_t head_hwvld;
	logic                   head_err;
	logic                   q_empty;
	logic                   q_full;
	logic                   q_almost_full;
	logic                   room_for_fetch;

	// ---------------------------------------------------------
	// address side
	// ---------------------------------------------------------

	fetch_sequencer #(
		.reset_vector    (reset_vector)
	) u_seq (
		.clk             (clk),
		.rst_n           (rst_n),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data_vld    (mem_data_vld),
		.q_full          (q_full),
		.q_almost_full   (q_almost_full),
		.jump_now        (jump_now),
		.flush_pending   (flush_pending),
		.mem_data_hwvld  (mem_data_hwvld)
	);

	// ---------------------------------------------------------
	// data side, queue and buffer both watch the bus
	// ---------------------------------------------------------

	prefetch_queue u_queue (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_data       (mem_data),
		.mem_data_err   (mem_data_err),
		.mem_data_vld   (mem_data_vld),
		.mem_data_hwvld (mem_data_hwvld),
		.flush_pending  (flush_pending),
		.jump_now       (jump_now),
		.room_for_fetch (room_for_fetch),
		.head_data      (head_data),
		.head_hwvld     (head_hwvld),
		.head_err       (head_err),
		.q_empty        (q_empty),
		.q_full         (q_full),
		.q_almost_full  (q_almost_full)
	);

	instr_buffer u_buf (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_data       (mem_data),
		.mem_data_err   (mem_data_err),
		.mem_data_vld   (mem_data_vld),
		.mem_data_hwvld (mem_data_hwvld),
		.flush_pending  (flush_pending),
		.jump_now       (jump_now),
		.head_data      (head_data),
		.head_hwvld     (head_hwvld),
		.head_err       (head_err),
		.q_empty        (q_empty),
		.cir_use        (cir_use),
		.room_for_fetch (room_for_fetch),
		.cir            (cir),
		.cir_vld        (cir_vld),
		.cir_err        (cir_err)
	);

endmodule

`default_nettype wire

// File: tb_frontend.sv
// testbench for the fetch front end with a bus memory model, a decode
// model, random jumps and the checks that compare against both
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

	localparam frontend_pkg::addr_t reset_vector = 32'h0000_0100;
	localparam int reset_cycles = 10;
	// instructions decode has to consume before the run ends
	localparam int n_instr = 600;
	localparam int cycle_limit = 40 * n_instr + reset_cycles;
	// words in this byte range answer with a bus error
	localparam frontend_pkg::addr_t err_lo = 32'h0000_0180;
	localparam frontend_pkg::addr_t err_hi = 32'h0000_01c0;

	logic clk;
	logic rst_n;
	frontend_pkg::addr_t mem_addr;
	logic mem_addr_vld;
	logic mem_addr_rdy;
	frontend_pkg::word_t mem_data;
	logic mem_data_err;
	logic mem_data_vld;
	frontend_pkg::addr_t jump_target;
	logic jump_target_vld;
	logic jump_target_rdy;
	logic [2*frontend_pkg::w_hw-1:0] cir;
	frontend_pkg::hw_count_t cir_vld;
	frontend_pkg::hw_count_t cir_use;
	frontend_pkg::hw_mask_t cir_err;

	// the bus model keeps the accepted addresses and the cycle each answer may go out
	frontend_pkg::addr_t resp_q [$];
	int resp_due [$];
	int out_cnt = 0;
	int cyc = 0;
	bit first_seen = 1'b0;
	bit hold_vld = 1'b0;
	frontend_pkg::addr_t hold_addr = '0;
	// decode model state
	frontend_pkg::addr_t exp_pc = reset_vector;
	int instr_cnt = 0;

	frontend_top #(
		.reset_vector    (reset_vector)
	) uut (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_use         (cir_use),
		.cir_err         (cir_err)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ---------------------------------------------------------
	// memory contents and error window
	// ---------------------------------------------------------

	// every halfword is built from its own address, offsets 6 and 12 of
	// each 16-byte block start a 32-bit instruction
	function automatic logic [frontend_pkg::w_hw-1:0] hw_at(frontend_pkg::addr_t a);
		logic [13:0] body;
		logic [1:0] len;
		body = a[14:1] ^ a[28:15] ^ {11'd0, a[31:29]};
		len = (a[3:1] == 3'd3 || a[3:1] == 3'd6) ? 2'b11 : {a[2], 1'b0};
		return {body, len};
	endfunction

	function automatic frontend_pkg::word_t word_at(frontend_pkg::addr_t a);
		return {hw_at(a + 32'd2), hw_at(a)};
	endfunction

	// the error belongs to the whole word holding the halfword
	function automatic logic in_err(frontend_pkg::addr_t a);
		frontend_pkg::addr_t w;
		w = {a[31:2], 2'b00};
		return (w >= err_lo) && (w < err_hi);
	endfunction

	// ---------------------------------------------------------
	// reporting and compare tasks
	// ---------------------------------------------------------

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_addr(string name, frontend_pkg::addr_t got, frontend_pkg::addr_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic check_hw(string name, logic [frontend_pkg::w_hw-1:0] got,
			logic [frontend_pkg::w_hw-1:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail %s got 0x%04h expected 0x%04h", name, got, exp));
		end
	endtask

	task automatic check_mask(string name, frontend_pkg::hw_mask_t got,
			frontend_pkg::hw_mask_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail %s got 0x%01h expected 0x%01h", name, got, exp));
		end
	endtask

	// takes the instruction in the window if it is complete and checks
	// its halfwords and error bits against the expected pc
	task automatic decode_step(output frontend_pkg::hw_count_t use_n);
		use_n = 2'd0;
		if (cir_vld == 2'd2 && cir[1:0] == 2'b11) begin
			check_hw("cir[15:0]", cir[15:0], hw_at(exp_pc));
			check_hw("cir[31:16]", cir[31:16], hw_at(exp_pc + 32'd2));
			check_mask("cir_err", cir_err, {in_err(exp_pc + 32'd2), in_err(exp_pc)});
			use_n = 2'd2;
		end else if (cir_vld != 2'd0 && cir[1:0] != 2'b11) begin
			check_hw("cir[15:0]", cir[15:0], hw_at(exp_pc));
			check_mask("cir_err", {1'b0, cir_err[0]}, {1'b0, in_err(exp_pc)});
			use_n = 2'd1;
		end
		exp_pc = exp_pc + 32'd2 * use_n;
		if (use_n != 2'd0) begin
			instr_cnt = instr_cnt + 1;
		end
	endtask

	// ---------------------------------------------------------
	// bus, decode and jump models with the protocol checks
	// ---------------------------------------------------------

	// all values read here are the ones before the edge, new inputs go
	// out as non-blocking assignments
	always @(posedge clk) begin : model
		int delay;
		frontend_pkg::hw_count_t use_n;
		frontend_pkg::addr_t resp_addr;
		if (cyc == 0) begin
			void'($urandom(4));
		end
		cyc = cyc + 1;
		if (cyc > cycle_limit) begin
			stop_run("timeout, decode did not consume all instructions in time");
		end
		mem_addr_rdy <= ($urandom % 10) < 7;
		if (!rst_n) begin
			if (cyc > 1 && (mem_addr_vld || jump_target_rdy || cir_vld != 2'd0)) begin
				stop_run("the DUT was active while reset was asserted");
			end
		end else begin
			// a request that was offered and refused must stay as it was
			if (hold_vld) begin
				if (!mem_addr_vld) begin
					stop_run("a request was withdrawn before it was accepted");
				end
				check_addr("mem_addr", mem_addr, hold_addr);
			end
			// requests only ever name whole words
			if (mem_addr_vld) begin
				check_addr("mem_addr[1:0]", mem_addr & 32'h0000_0003, 32'h0000_0000);
			end
			hold_vld = mem_addr_vld && !mem_addr_rdy;
			hold_addr = mem_addr;
			if (mem_data_vld) begin
				out_cnt = out_cnt - 1;
			end
			if (mem_addr_vld && mem_addr_rdy) begin
				if (!first_seen) begin
					check_addr("mem_addr", mem_addr, reset_vector);
				end
				first_seen = 1'b1;
				out_cnt = out_cnt + 1;
				if (out_cnt > 2) begin
					stop_run("more than two requests were waiting for a response");
				end
				delay = 1 + $urandom % 3;
				resp_q.push_back(mem_addr);
				resp_due.push_back(cyc + delay - 1);
			end
			// one in-order answer per cycle once its delay has run out
			if (resp_q.size() > 0 && resp_due[0] <= cyc) begin
				resp_addr = resp_q.pop_front();
				void'(resp_due.pop_front());
				mem_data <= word_at(resp_addr);
				mem_data_err <= in_err(resp_addr);
				mem_data_vld <= 1'b1;
			end else begin
				mem_data_vld <= 1'b0;
			end
			// decode never consumes while a jump is offered, and only after
			// an idle cycle, so the window it checked is the one it takes
			use_n = 2'd0;
			if (jump_target_vld && jump_target_rdy) begin
				exp_pc = jump_target;
				jump_target_vld <= 1'b0;
			end else if (jump_target_vld) begin
				// the sequencer holds a request, the jump stays offered
				use_n = 2'd0;
			end else if (first_seen && $urandom % 40 == 0) begin
				jump_target <= reset_vector + (($urandom % 1024) << 1);
				jump_target_vld <= 1'b1;
			end else if (cir_use == 2'd0 && $urandom % 4 != 0) begin
				decode_step(use_n);
			end
			cir_use <= use_n;
		end
	end

	// ---------------------------------------------------------
	// reset and end of run
	// ---------------------------------------------------------

	initial begin
		rst_n = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_data = '0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		jump_target = '0;
		jump_target_vld = 1'b0;
		cir_use = 2'd0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		while (instr_cnt < n_instr) begin
			@(posedge clk);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
frontend_pkg.sv
fetch_sequencer.sv
prefetch_queue.sv
instr_buffer.sv
frontend_top.sv
tb_frontend.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line is a failure
run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
